// File: source/datapath_pkg.sv
//================================================
// Datapath package
// Program counter, lane and operand widths
// Bundle geometry and register address sizes
// Reset constants of the decode stage
//================================================
package datapath_pkg;

	// Program counter and operand lanes
	localparam int pc_width        = 32;
	localparam int dword_width     = 32;
	localparam int lane_count      = 4;

	// One scratch counter per dimension, one mask bit each
	localparam int dimension_count = 4;

	// Register file addressing, 64 registers
	localparam int gpr_addr_width  = 6;
	localparam int index_width     = 6;

	// Instruction bundle, four unit instructions
	localparam int uinst_width     = 32;
	localparam int slot_count      = 4;
	localparam int bundle_width    = uinst_width * slot_count;

	//================================================
	// Reset constants
	//================================================
	// All ones bundle is a bubble
	localparam logic [bundle_width-1:0] bubble_bundle = '1;

	// No counter selected
	localparam logic [dimension_count-1:0] mask_none = '0;

endpackage

// File: source/isa_pkg.sv
//================================================
// ISA package
// Opcodes of the special unit instructions
// Operation and counter control formats
// Decoded unit instruction union
//================================================
package isa_pkg;

	// Counter control and bubble opcodes
	localparam logic [7:0] opcode_gsc_ctrl = 8'hF0;
	localparam logic [7:0] opcode_nop      = 8'hFF;

	// Ordinary operation format
	typedef struct packed {
		logic [7:0]                              opcode;
		logic [datapath_pkg::gpr_addr_width-1:0] dest;
		// Destination is relative to the index
		logic                                    dest_rel;
		logic [datapath_pkg::gpr_addr_width-1:0] src0;
		logic [datapath_pkg::gpr_addr_width-1:0] src1;
		// Source 1 takes the scratch counters
		logic                                    src1_coord;
		logic [3:0]                              spare;
	} op_form_t;

	// Scratch counter control format
	typedef struct packed {
		logic [7:0]                               opcode;
		logic [datapath_pkg::dimension_count-1:0] rst_mask;
		logic [datapath_pkg::dimension_count-1:0] inc_mask;
		logic [15:0]                              spare;
	} ctrl_form_t;

	// One word, two views, chosen by the opcode
	typedef union packed {
		op_form_t   op;
		ctrl_form_t ctrl;
	} uinst_t;

	// True for an operation, false for control or bubble
	function automatic logic is_op_form(input uinst_t inst);
		return (inst.op.opcode != opcode_gsc_ctrl) && (inst.op.opcode != opcode_nop);
	endfunction

	// True for a counter control instruction
	function automatic logic is_ctrl_form(input uinst_t inst);
		return inst.ctrl.opcode == opcode_gsc_ctrl;
	endfunction

	// Slot order in a bundle, top bits first:
	// phase-0 main, phase-0 sub, phase-1 main, phase-1 sub

endpackage

// File: source/src_coordinate.sv
//================================================
// Source 1 coordinate substitution
// Replaces the source 1 lanes with the scratch
// counter values on request of phase-1 main
//================================================
`timescale 1ns/1ps

module src_coordinate (
	// Raw phase-1 main instruction
	input  isa_pkg::uinst_t p1_main,
	// Source 1 operand, lane 0 in the low bits
	input  logic [datapath_pkg::lane_count-1:0][datapath_pkg::dword_width-1:0] src1a,
	// Current scratch counters
	input  logic [datapath_pkg::dimension_count-1:0][datapath_pkg::dword_width-1:0] gsc_value,
	// Source 1 after substitution
	output logic [datapath_pkg::lane_count-1:0][datapath_pkg::dword_width-1:0] src1a_coord
);

	import datapath_pkg::*;
	import isa_pkg::*;

	logic coord_sel;

	// Only an operation may ask for coordinates
	assign coord_sel = is_op_form(p1_main) && p1_main.op.src1_coord;

	always_comb begin
		for (int i = 0; i < lane_count; i++) begin
			// Lane i gets counter i
			if (coord_sel) begin
				src1a_coord[i] = gsc_value[i];
			end else begin
				src1a_coord[i] = src1a[i];
			end
		end
	end

endmodule

// File: source/inst_coordinate.sv
//================================================
// Destination coordinate resolution
// Turns relative destinations of all four slots
// into absolute ones and reports the phase-0
// main destination and the relative index
//================================================
`timescale 1ns/1ps

module inst_coordinate (
	// Incoming bundle
	input  logic [datapath_pkg::bundle_width-1:0] uinstx4,
	// Source 0 operand, lane 0 carries the index
	input  logic [datapath_pkg::lane_count-1:0][datapath_pkg::dword_width-1:0] src0a,
	// Bundle with absolute destinations
	output logic [datapath_pkg::bundle_width-1:0] uinstx4_coord,
	// Resolved destination of phase-0 main
	output logic [datapath_pkg::gpr_addr_width-1:0] ref_addr_dest,
	// Relative index in use
	output logic [datapath_pkg::index_width-1:0] ref_addr_relative
);

	import datapath_pkg::*;
	import isa_pkg::*;

	logic [slot_count-1:0][uinst_width-1:0] slots_in;
	logic [slot_count-1:0][uinst_width-1:0] slots_out;
	logic [index_width-1:0]                 index;
	uinst_t                                 p0_main;

	// Slot 3 is phase-0 main, slot 0 is phase-1 sub
	assign slots_in = uinstx4;

	// Index from the low bits of lane 0
	assign index = src0a[0][index_width-1:0];

	//================================================
	// Per slot rewrite
	//================================================
	always_comb begin
		uinst_t slot;
		for (int s = 0; s < slot_count; s++) begin
			slot = slots_in[s];
			// Control and bubble slots stay as they are
			if (is_op_form(slot) && slot.op.dest_rel) begin
				// Six bit sum wraps modulo 64
				slot.op.dest     = slot.op.dest + index;
				slot.op.dest_rel = 1'b0;
			end
			slots_out[s] = slot;
		end
	end

	assign uinstx4_coord = slots_out;

	// Reference address from the resolved phase-0 main slot
	assign p0_main           = slots_out[slot_count-1];
	assign ref_addr_dest     = p0_main.op.dest;
	assign ref_addr_relative = index;

endmodule

// File: source/gsc_control.sv
//================================================
// Scratch counter control decode
// Builds reset and increment masks from the
// phase-1 slots of a coordinated bundle
//================================================
`timescale 1ns/1ps

module gsc_control (
	// Phase-1 main in entry 1, phase-1 sub in entry 0
	input  logic [1:0][datapath_pkg::uinst_width-1:0] p1_pair,
	// Counter reset mask
	output logic [datapath_pkg::dimension_count-1:0]  gsc_rst,
	// Counter increment mask
	output logic [datapath_pkg::dimension_count-1:0]  gsc_inc
);

	import datapath_pkg::*;
	import isa_pkg::*;

	always_comb begin
		uinst_t slot;
		gsc_rst = mask_none;
		gsc_inc = mask_none;
		// Both phase-1 slots may carry control, masks merge
		for (int k = 0; k < 2; k++) begin
			slot = p1_pair[k];
			if (is_ctrl_form(slot)) begin
				gsc_rst = gsc_rst | slot.ctrl.rst_mask;
				gsc_inc = gsc_inc | slot.ctrl.inc_mask;
			end
		end
	end

endmodule

// File: source/scratch_counters.sv
//================================================
// Global scratch counters
// One 32-bit counter per dimension, cleared or
// incremented by its own mask bit
//================================================
`timescale 1ns/1ps

module scratch_counters (
	input  logic                                        clk,
	input  logic                                        reset,
	// Registered masks from the decode stage
	input  logic [datapath_pkg::dimension_count-1:0]    gsc_rst,
	input  logic [datapath_pkg::dimension_count-1:0]    gsc_inc,
	// Counter values, counter i in entry i
	output logic [datapath_pkg::dimension_count-1:0][datapath_pkg::dword_width-1:0] gsc_value
);

	import datapath_pkg::*;

	always_ff @(posedge clk) begin
		if (reset) begin
			gsc_value <= '0;
		end else begin
			for (int i = 0; i < dimension_count; i++) begin
				// Clear beats increment on the same bit
				if (gsc_rst[i]) begin
					gsc_value[i] <= '0;
				end else if (gsc_inc[i]) begin
					// Wraps at 32 bits
					gsc_value[i] <= gsc_value[i] + 1'b1;
				end
			end
		end
	end

endmodule

// File: source/decode_stage2.sv
//================================================
// Decode stage 2
// Destination and source coordinate blocks,
// counter control decode and the pipeline
// register holding the stage results
//================================================
`timescale 1ns/1ps

module decode_stage2 (
	input  logic                                      clk,
	input  logic                                      reset,
	// Stage inputs
	input  logic [datapath_pkg::pc_width-1:0]         pc,
	input  logic [datapath_pkg::bundle_width-1:0]     uinstx4,
	input  logic [datapath_pkg::lane_count-1:0][datapath_pkg::dword_width-1:0] src0a,
	input  logic [datapath_pkg::lane_count-1:0][datapath_pkg::dword_width-1:0] src0b,
	input  logic [datapath_pkg::lane_count-1:0][datapath_pkg::dword_width-1:0] src1a,
	// Scratch counters feed source substitution
	input  logic [datapath_pkg::dimension_count-1:0][datapath_pkg::dword_width-1:0] gsc_value,
	// Registered stage outputs
	output logic [datapath_pkg::pc_width-1:0]         pc_out,
	output logic [datapath_pkg::bundle_width-1:0]     uinstx4_out,
	output logic [datapath_pkg::lane_count-1:0][datapath_pkg::dword_width-1:0] src0a_out,
	output logic [datapath_pkg::lane_count-1:0][datapath_pkg::dword_width-1:0] src0b_out,
	output logic [datapath_pkg::lane_count-1:0][datapath_pkg::dword_width-1:0] src1a_out,
	output logic [datapath_pkg::gpr_addr_width-1:0]   ref_addr_dest,
	output logic [datapath_pkg::index_width-1:0]      ref_addr_relative,
	// Registered counter masks
	output logic [datapath_pkg::dimension_count-1:0]  gsc_rst,
	output logic [datapath_pkg::dimension_count-1:0]  gsc_inc
);

	import datapath_pkg::*;
	import isa_pkg::*;

	uinst_t                                 p1_main;
	logic [bundle_width-1:0]                uinstx4_coord;
	logic [lane_count-1:0][dword_width-1:0] src1a_coord;
	logic [gpr_addr_width-1:0]              ref_addr_dest_next;
	logic [index_width-1:0]                 ref_addr_relative_next;
	logic [dimension_count-1:0]             gsc_rst_next;
	logic [dimension_count-1:0]             gsc_inc_next;

	// Raw phase-1 main, third slot from the top
	assign p1_main = uinstx4[2*uinst_width-1:uinst_width];

	//================================================
	// Coordinate blocks
	//================================================
	src_coordinate src_coordinate_inst (
		.p1_main     (p1_main),
		.src1a       (src1a),
		.gsc_value   (gsc_value),
		.src1a_coord (src1a_coord)
	);

	inst_coordinate inst_coordinate_inst (
		.uinstx4           (uinstx4),
		.src0a             (src0a),
		.uinstx4_coord     (uinstx4_coord),
		.ref_addr_dest     (ref_addr_dest_next),
		.ref_addr_relative (ref_addr_relative_next)
	);

	// Masks come from the coordinated phase-1 slots
	gsc_control gsc_control_inst (
		.p1_pair (uinstx4_coord[2*uinst_width-1:0]),
		.gsc_rst (gsc_rst_next),
		.gsc_inc (gsc_inc_next)
	);

	//================================================
	// Pipeline register, advances every cycle
	//================================================
	always_ff @(posedge clk) begin
		if (reset) begin
			pc_out            <= '0;
			uinstx4_out       <= bubble_bundle;
			src0a_out         <= '0;
			src0b_out         <= '0;
			src1a_out         <= '0;
			ref_addr_dest     <= '0;
			ref_addr_relative <= '0;
			gsc_rst           <= mask_none;
			gsc_inc           <= mask_none;
		end else begin
			pc_out            <= pc;
			uinstx4_out       <= uinstx4_coord;
			src0a_out         <= src0a;
			src0b_out         <= src0b;
			src1a_out         <= src1a_coord;
			ref_addr_dest     <= ref_addr_dest_next;
			ref_addr_relative <= ref_addr_relative_next;
			gsc_rst           <= gsc_rst_next;
			gsc_inc           <= gsc_inc_next;
		end
	end

endmodule

// File: source/decode_top.sv
//================================================
// Decode top
// Decode stage 2 with the global scratch
// counters that its masks control
//================================================
`timescale 1ns/1ps

module decode_top (
	input  logic                                      clk,
	input  logic                                      reset,
	// Bundle, PC and operands from decode stage 1
	input  logic [datapath_pkg::pc_width-1:0]         pc,
	input  logic [datapath_pkg::bundle_width-1:0]     uinstx4,
	input  logic [datapath_pkg::lane_count-1:0][datapath_pkg::dword_width-1:0] src0a,
	input  logic [datapath_pkg::lane_count-1:0][datapath_pkg::dword_width-1:0] src0b,
	input  logic [datapath_pkg::lane_count-1:0][datapath_pkg::dword_width-1:0] src1a,
	// Coordinated stage results
	output logic [datapath_pkg::pc_width-1:0]         pc_out,
	output logic [datapath_pkg::bundle_width-1:0]     uinstx4_out,
	output logic [datapath_pkg::lane_count-1:0][datapath_pkg::dword_width-1:0] src0a_out,
	output logic [datapath_pkg::lane_count-1:0][datapath_pkg::dword_width-1:0] src0b_out,
	output logic [datapath_pkg::lane_count-1:0][datapath_pkg::dword_width-1:0] src1a_out,
	output logic [datapath_pkg::gpr_addr_width-1:0]   ref_addr_dest,
	output logic [datapath_pkg::index_width-1:0]      ref_addr_relative,
	// Counter values, also fed back into the stage
	output logic [datapath_pkg::dimension_count-1:0][datapath_pkg::dword_width-1:0] gsc_value
);

	import datapath_pkg::*;

	// Masks from the stage register to the counters
	logic [dimension_count-1:0] gsc_rst;
	logic [dimension_count-1:0] gsc_inc;

	decode_stage2 decode_stage2_inst (
		.clk               (clk),
		.reset             (reset),
		.pc                (pc),
		.uinstx4           (uinstx4),
		.src0a             (src0a),
		.src0b             (src0b),
		.src1a             (src1a),
		.gsc_value         (gsc_value),
		.pc_out            (pc_out),
		.uinstx4_out       (uinstx4_out),
		.src0a_out         (src0a_out),
		.src0b_out         (src0b_out),
		.src1a_out         (src1a_out),
		.ref_addr_dest     (ref_addr_dest),
		.ref_addr_relative (ref_addr_relative),
		.gsc_rst           (gsc_rst),
		.gsc_inc           (gsc_inc)
	);

	scratch_counters scratch_counters_inst (
		.clk       (clk),
		.reset     (reset),
		.gsc_rst   (gsc_rst),
		.gsc_inc   (gsc_inc),
		.gsc_value (gsc_value)
	);

endmodule

// File: verification/decode_properties.sv
//================================================
// Decode timing and reset properties
// One cycle latency of the stage outputs
// Mask and bundle values after reset
// Counter hold without a mask bit
//================================================
`timescale 1ns/1ps

module decode_properties (
	input logic                                       clk,
	input logic                                       reset,
	input logic [datapath_pkg::pc_width-1:0]          pc,
	input logic [datapath_pkg::lane_count-1:0][datapath_pkg::dword_width-1:0] src0a,
	input logic [datapath_pkg::lane_count-1:0][datapath_pkg::dword_width-1:0] src0b,
	input logic [datapath_pkg::lane_count-1:0][datapath_pkg::dword_width-1:0] src1a,
	input logic [datapath_pkg::pc_width-1:0]          pc_out,
	input logic [datapath_pkg::bundle_width-1:0]      uinstx4_out,
	input logic [datapath_pkg::lane_count-1:0][datapath_pkg::dword_width-1:0] src0a_out,
	input logic [datapath_pkg::lane_count-1:0][datapath_pkg::dword_width-1:0] src0b_out,
	input logic [datapath_pkg::lane_count-1:0][datapath_pkg::dword_width-1:0] src1a_out,
	input logic [datapath_pkg::index_width-1:0]       ref_addr_relative,
	input logic [datapath_pkg::dimension_count-1:0][datapath_pkg::dword_width-1:0] gsc_value,
	// Internal masks of decode_top
	input logic [datapath_pkg::dimension_count-1:0]   gsc_rst,
	input logic [datapath_pkg::dimension_count-1:0]   gsc_inc
);

	import datapath_pkg::*;

	// Set after the first edge so that $past has history
	logic past_valid;
	// Number of failed properties so far
	int   failure_count = 0;

	initial past_valid = 1'b0;

	always @(posedge clk) begin
		past_valid <= 1'b1;
	end

	//================================================
	// Stage outputs one cycle after the inputs
	//================================================
	pc_delay: assert property (@(posedge clk)
		past_valid && !$past(reset) |-> pc_out == $past(pc))
		else begin
			$error("pc_out is not pc of the previous cycle");
			failure_count++;
		end

	src0_delay: assert property (@(posedge clk)
		past_valid && !$past(reset) |-> src0a_out == $past(src0a) && src0b_out == $past(src0b))
		else begin
			$error("source 0 outputs are not the operands of the previous cycle");
			failure_count++;
		end

	// Source 1 is either passed on or replaced by the counters
	src1_delay: assert property (@(posedge clk)
		past_valid && !$past(reset) |->
		src1a_out == $past(src1a) || src1a_out == $past(gsc_value))
		else begin
			$error("src1a_out is neither src1a nor the counters of the previous cycle");
			failure_count++;
		end

	index_delay: assert property (@(posedge clk)
		past_valid && !$past(reset) |->
		ref_addr_relative == $past(src0a[0][index_width-1:0]))
		else begin
			$error("ref_addr_relative is not the index of the previous cycle");
			failure_count++;
		end

	//================================================
	// Reset values
	//================================================
	reset_values: assert property (@(posedge clk)
		past_valid && $past(reset) |->
		gsc_rst == '0 && gsc_inc == '0 && uinstx4_out == bubble_bundle)
		else begin
			$error("masks or bundle output wrong in the cycle after reset");
			failure_count++;
		end

	// A counter moves only on its own mask bit
	for (genvar i = 0; i < dimension_count; i++) begin : counter_hold
		hold: assert property (@(posedge clk)
			past_valid && !$past(reset) && !$past(gsc_rst[i]) && !$past(gsc_inc[i]) |->
			gsc_value[i] == $past(gsc_value[i]))
			else begin
				$error("counter %0d changed without a mask bit", i);
				failure_count++;
			end
	end

endmodule

bind decode_top decode_properties decode_properties_inst (.*);

// File: verification/decode_tb.sv
//================================================
// Decode stage 2 testbench
// Clock, reset and falling edge stimulus
// Reference model of the stage and counters
// Immediate checks, per test report, watchdog
//================================================
`timescale 1ns/1ps

module decode_tb;

	import datapath_pkg::*;
	import isa_pkg::*;

	typedef logic [lane_count-1:0][dword_width-1:0] lanes_t;

	// Reset and the cycles of tests 1 to 5
	localparam int test_cycles   = 2 + 6 + 9 + 7 + 10 + 7;
	localparam int margin_cycles = 20;
	localparam logic [uinst_width-1:0] nop_word = '1;

	logic                                        clk;
	logic                                        reset;
	logic [pc_width-1:0]                         pc;
	logic [bundle_width-1:0]                     uinstx4;
	lanes_t                                      src0a;
	lanes_t                                      src0b;
	lanes_t                                      src1a;
	logic [pc_width-1:0]                         pc_out;
	logic [bundle_width-1:0]                     uinstx4_out;
	lanes_t                                      src0a_out;
	lanes_t                                      src0b_out;
	lanes_t                                      src1a_out;
	logic [gpr_addr_width-1:0]                   ref_addr_dest;
	logic [index_width-1:0]                      ref_addr_relative;
	logic [dimension_count-1:0][dword_width-1:0] gsc_value;

	// Expected state after the last rising edge
	logic [pc_width-1:0]                         exp_pc;
	logic [bundle_width-1:0]                     exp_bundle;
	lanes_t                                      exp_src0a;
	lanes_t                                      exp_src0b;
	lanes_t                                      exp_src1a;
	logic [gpr_addr_width-1:0]                   exp_dest;
	logic [index_width-1:0]                      exp_rel;
	logic [dimension_count-1:0]                  exp_rst;
	logic [dimension_count-1:0]                  exp_inc;
	logic [dimension_count-1:0][dword_width-1:0] exp_cnt;

	integer seed;
	int     test_errors;
	int     tests_passed;
	int     tests_failed;
	int     property_failures_seen;

	decode_top decode_top_inst (
		.clk               (clk),
		.reset             (reset),
		.pc                (pc),
		.uinstx4           (uinstx4),
		.src0a             (src0a),
		.src0b             (src0b),
		.src1a             (src1a),
		.pc_out            (pc_out),
		.uinstx4_out       (uinstx4_out),
		.src0a_out         (src0a_out),
		.src0b_out         (src0b_out),
		.src1a_out         (src1a_out),
		.ref_addr_dest     (ref_addr_dest),
		.ref_addr_relative (ref_addr_relative),
		.gsc_value         (gsc_value)
	);

	initial clk = 1'b0;

	always #5 clk = ~clk;

	//================================================
	// Stimulus helpers
	//================================================
	function automatic logic [31:0] rnd();
		return $random(seed);
	endfunction

	function automatic lanes_t random_lanes();
		lanes_t l;
		for (int i = 0; i < lane_count; i++) begin
			l[i] = rnd();
		end
		return l;
	endfunction

	// Operation with random fields and an opcode below 8'h80
	function automatic logic [uinst_width-1:0] op_word(input logic [31:0] r,
			input logic [gpr_addr_width-1:0] dest, input logic rel, input logic coord);
		uinst_t u;
		u               = r;
		u.op.opcode     = {1'b0, r[30:24]};
		u.op.dest       = dest;
		u.op.dest_rel   = rel;
		u.op.src1_coord = coord;
		return u;
	endfunction

	function automatic logic [uinst_width-1:0] ctrl_word(input logic [3:0] rst_m,
			input logic [3:0] inc_m);
		uinst_t u;
		u               = '0;
		u.ctrl.opcode   = opcode_gsc_ctrl;
		u.ctrl.rst_mask = rst_m;
		u.ctrl.inc_mask = inc_m;
		u.ctrl.spare    = 16'h5a3c;
		return u;
	endfunction

	task automatic report_mismatch(input string name, input logic [bundle_width-1:0] expected,
			input logic [bundle_width-1:0] actual);
		$display("[ERROR] %0t ns %s expected %0h actual %0h", $time, name, expected, actual);
		test_errors++;
	endtask

	//================================================
	// Checks and reference model
	//================================================
	task automatic check_outputs();
		assert (pc_out === exp_pc) else report_mismatch("pc_out", exp_pc, pc_out);
		assert (uinstx4_out === exp_bundle)
			else report_mismatch("uinstx4_out", exp_bundle, uinstx4_out);
		assert (src0a_out === exp_src0a) else report_mismatch("src0a_out", exp_src0a, src0a_out);
		assert (src0b_out === exp_src0b) else report_mismatch("src0b_out", exp_src0b, src0b_out);
		assert (src1a_out === exp_src1a) else report_mismatch("src1a_out", exp_src1a, src1a_out);
		assert (ref_addr_dest === exp_dest)
			else report_mismatch("ref_addr_dest", exp_dest, ref_addr_dest);
		assert (ref_addr_relative === exp_rel)
			else report_mismatch("ref_addr_relative", exp_rel, ref_addr_relative);
		assert (gsc_value === exp_cnt) else report_mismatch("gsc_value", exp_cnt, gsc_value);
	endtask

	task automatic drive_and_predict(input logic [pc_width-1:0] pc_v,
			input logic [bundle_width-1:0] bundle_v, input lanes_t s0a, input lanes_t s0b,
			input lanes_t s1a);
		uinst_t                     slot;
		logic [bundle_width-1:0]    coord;
		logic [index_width-1:0]     idx;
		logic [dimension_count-1:0] rst_next;
		logic [dimension_count-1:0] inc_next;
		pc       = pc_v;
		uinstx4  = bundle_v;
		src0a    = s0a;
		src0b    = s0b;
		src1a    = s1a;
		idx      = s0a[0][index_width-1:0];
		coord    = bundle_v;
		rst_next = '0;
		inc_next = '0;
		for (int s = 0; s < slot_count; s++) begin
			slot = bundle_v[s*uinst_width +: uinst_width];
			// Relative destination of an operation wraps modulo 64 registers
			if (slot.op.opcode != opcode_gsc_ctrl && slot.op.opcode != opcode_nop &&
					slot.op.dest_rel) begin
				slot.op.dest     = (int'(slot.op.dest) + int'(idx)) % 64;
				slot.op.dest_rel = 1'b0;
			end
			coord[s*uinst_width +: uinst_width] = slot;
			// Phase-1 slots sit in the two lowest words
			if (s < 2 && slot.ctrl.opcode == opcode_gsc_ctrl) begin
				rst_next = rst_next | slot.ctrl.rst_mask;
				inc_next = inc_next | slot.ctrl.inc_mask;
			end
		end
		// Phase-1 main asks for the counters of this cycle
		slot      = bundle_v[2*uinst_width-1:uinst_width];
		exp_src1a = s1a;
		if (slot.op.opcode != opcode_gsc_ctrl && slot.op.opcode != opcode_nop &&
				slot.op.src1_coord) begin
			exp_src1a = exp_cnt;
		end
		exp_pc     = pc_v;
		exp_bundle = coord;
		exp_src0a  = s0a;
		exp_src0b  = s0b;
		slot       = coord[bundle_width-1 -: uinst_width];
		exp_dest   = slot.op.dest;
		exp_rel    = idx;
		// Counters follow the masks registered one edge earlier
		for (int i = 0; i < dimension_count; i++) begin
			if (exp_rst[i]) begin
				exp_cnt[i] = '0;
			end else if (exp_inc[i]) begin
				exp_cnt[i] = exp_cnt[i] + 1;
			end
		end
		exp_rst = rst_next;
		exp_inc = inc_next;
	endtask

	task automatic apply_bundle(input logic [pc_width-1:0] pc_v,
			input logic [bundle_width-1:0] bundle_v, input lanes_t s0a, input lanes_t s0b,
			input lanes_t s1a);
		@(negedge clk);
		check_outputs();
		drive_and_predict(pc_v, bundle_v, s0a, s0b, s1a);
	endtask

	task automatic apply_bubble();
		apply_bundle(rnd(), bubble_bundle, random_lanes(), random_lanes(), random_lanes());
	endtask

	// Plain phase-0 slots around the given phase-1 pair
	task automatic apply_phase1(input logic [uinst_width-1:0] p1_main,
			input logic [uinst_width-1:0] p1_sub);
		apply_bundle(rnd(), {op_word(rnd(), 6'(rnd()), 1'b0, 1'b0),
			op_word(rnd(), 6'(rnd()), 1'b0, 1'b0), p1_main, p1_sub},
			random_lanes(), random_lanes(), random_lanes());
	endtask

	task automatic finish_test(input string name);
		int property_failures_new;
		property_failures_new = decode_top_inst.decode_properties_inst.failure_count -
			property_failures_seen;
		property_failures_seen = property_failures_seen + property_failures_new;
		if (test_errors == 0 && property_failures_new == 0) begin
			tests_passed++;
			$display("PASS %s", name);
		end else begin
			tests_failed++;
			$display("FAIL %s with %0d mismatches and %0d property failures", name,
				test_errors, property_failures_new);
		end
		test_errors = 0;
	endtask

	//================================================
	// Test sequence
	//================================================
	initial begin
		lanes_t s0;
		seed                   = 32'ha6b56275;
		test_errors            = 0;
		tests_passed           = 0;
		tests_failed           = 0;
		property_failures_seen = 0;
		reset                  = 1'b1;
		pc                     = '0;
		uinstx4                = bubble_bundle;
		src0a                  = '0;
		src0b                  = '0;
		src1a                  = '0;
		exp_pc                 = '0;
		exp_bundle             = bubble_bundle;
		exp_src0a              = '0;
		exp_src0b              = '0;
		exp_src1a              = '0;
		exp_dest               = '0;
		exp_rel                = '0;
		exp_rst                = '0;
		exp_inc                = '0;
		exp_cnt                = '0;
		repeat (2) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		// Test 1 covers reset values and a run of bubbles
		check_outputs();
		drive_and_predict('0, bubble_bundle, '0, '0, '0);
		repeat (5) apply_bubble();
		finish_test("reset values and bubbles");

		// Test 2 sends plain operations back to back
		repeat (8) begin
			apply_bundle(rnd(), {op_word(rnd(), 6'(rnd()), 1'b0, 1'b0),
				op_word(rnd(), 6'(rnd()), 1'b0, 1'b0), op_word(rnd(), 6'(rnd()), 1'b0, 1'b0),
				op_word(rnd(), 6'(rnd()), 1'b0, 1'b0)},
				random_lanes(), random_lanes(), random_lanes());
		end
		apply_bubble();
		finish_test("pass-through and latency");

		// Test 3 covers relative destinations
		s0    = random_lanes();
		s0[0] = 32'h0000_0005;
		// Control word whose inc bit 1 lines up with dest_rel
		apply_bundle(rnd(), {op_word(rnd(), 6'd10, 1'b1, 1'b0),
			op_word(rnd(), 6'd60, 1'b1, 1'b0), op_word(rnd(), 6'd7, 1'b0, 1'b0),
			ctrl_word(4'b0000, 4'b0010)}, s0, random_lanes(), random_lanes());
		s0[0] = 32'hffff_ffff;
		apply_bundle(rnd(), {op_word(rnd(), 6'd63, 1'b1, 1'b0),
			op_word(rnd(), 6'd1, 1'b1, 1'b0), nop_word, op_word(rnd(), 6'd32, 1'b1, 1'b0)},
			s0, random_lanes(), random_lanes());
		repeat (4) begin
			apply_bundle(rnd(), {op_word(rnd(), 6'(rnd()), 1'b1, 1'b0),
				op_word(rnd(), 6'(rnd()), 1'b1, 1'b0), op_word(rnd(), 6'(rnd()), 1'b1, 1'b0),
				op_word(rnd(), 6'(rnd()), 1'b1, 1'b0)},
				random_lanes(), random_lanes(), random_lanes());
		end
		apply_bubble();
		finish_test("relative destinations");

		// Test 4 covers counter control and ends with counters at 1, 3, 4 and 5
		apply_phase1(ctrl_word(4'b1111, 4'b0000), nop_word);
		apply_phase1(ctrl_word(4'b0000, 4'b1111), nop_word);
		apply_phase1(nop_word, ctrl_word(4'b0000, 4'b1110));
		apply_phase1(ctrl_word(4'b0000, 4'b1100), nop_word);
		apply_phase1(ctrl_word(4'b0000, 4'b1000), nop_word);
		apply_phase1(ctrl_word(4'b0000, 4'b0011), ctrl_word(4'b0000, 4'b0100));
		// Reset beats increment on counter 0
		apply_phase1(ctrl_word(4'b0001, 4'b0001), ctrl_word(4'b0000, 4'b0001));
		apply_phase1(ctrl_word(4'b0000, 4'b1000), ctrl_word(4'b0000, 4'b0001));
		repeat (2) apply_bubble();
		finish_test("counter control");

		// Test 5 covers coordinate substitution
		apply_phase1(op_word(rnd(), 6'(rnd()), 1'b0, 1'b1), nop_word);
		// Flag in phase-0 main only
		apply_bundle(rnd(), {op_word(rnd(), 6'(rnd()), 1'b0, 1'b1),
			op_word(rnd(), 6'(rnd()), 1'b0, 1'b0), op_word(rnd(), 6'(rnd()), 1'b0, 1'b0),
			nop_word}, random_lanes(), random_lanes(), random_lanes());
		apply_phase1(op_word(rnd(), 6'(rnd()), 1'b0, 1'b1), ctrl_word(4'b0000, 4'b1111));
		apply_phase1(op_word(rnd(), 6'(rnd()), 1'b0, 1'b1), nop_word);
		apply_phase1(op_word(rnd(), 6'(rnd()), 1'b0, 1'b1), nop_word);
		apply_bubble();
		@(negedge clk);
		check_outputs();
		finish_test("coordinate substitution");

		$display("tests passed %0d, tests failed %0d", tests_passed, tests_failed);
		if (tests_failed == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

	// Watchdog sized from the test length
	initial begin
		#((test_cycles + margin_cycles) * 10);
		$display("Timeout, the tests did not reach their end in time");
		$display("Test failed");
		$finish;
	end

endmodule

// File: list.f
source/datapath_pkg.sv
source/isa_pkg.sv
source/src_coordinate.sv
source/inst_coordinate.sv
source/gsc_control.sv
source/scratch_counters.sv
source/decode_stage2.sv
source/decode_top.sv
verification/decode_properties.sv
verification/decode_tb.sv
